// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 codes for the ALU group
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Word size for loads and stores
    localparam logic [2:0] F3_WORD = 3'b010;

    // Selects SUB and SRA
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // One instruction word, viewed per format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
    } rv_instr_u;

endpackage

// ==== verilog/core_pkg.sv ====
package core_pkg;

    localparam int XLEN       = 32;
    localparam int LANES      = 2;
    localparam int REG_IDX_W  = 5;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_IDX_W = 8;

    // Lane that owns the data memory port
    localparam int MEM_LANE = 1;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_e;

    // Decoded control for one lane
    typedef struct packed {
        alu_op_e              alu_op;
        logic                 use_imm;
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      imm;
    } ctrl_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [XLEN-1:0] op_a;
        logic [XLEN-1:0] op_b;
    } issue_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] store_data;
    } exec_t;

    // Register write and retire report
    typedef struct packed {
        logic                 valid;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      data;
    } retire_t;

endpackage

// ==== verilog/instr_decoder.sv ====
module instr_decoder #(
    parameter int MEM_CAPABLE = 0
) (
    input  rv_isa_pkg::rv_instr_u          instr,
    input  logic                           valid,
    output core_pkg::ctrl_t                ctrl,
    output logic [core_pkg::REG_IDX_W-1:0] rs1,
    output logic [core_pkg::REG_IDX_W-1:0] rs2
);

    function automatic core_pkg::alu_op_e op_from_funct(
        input logic [2:0] funct3,
        input logic       alt
    );
        core_pkg::alu_op_e op;
        case (funct3)
            rv_isa_pkg::F3_ADD:  op = alt ? core_pkg::SUB : core_pkg::ADD;
            rv_isa_pkg::F3_SLL:  op = core_pkg::SLL;
            rv_isa_pkg::F3_SLT:  op = core_pkg::SLT;
            rv_isa_pkg::F3_SLTU: op = core_pkg::SLTU;
            rv_isa_pkg::F3_XOR:  op = core_pkg::XOR;
            rv_isa_pkg::F3_SR:   op = alt ? core_pkg::SRA : core_pkg::SRL;
            rv_isa_pkg::F3_OR:   op = core_pkg::OR;
            default:             op = core_pkg::AND;
        endcase
        return op;
    endfunction

    // Register fields sit at the same bits in every format
    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;

    always_comb
    begin
        ctrl    = '0;
        ctrl.rd = instr.r.rd;
        case (instr.r.opcode)
            rv_isa_pkg::OPC_OP:
            begin
                ctrl.alu_op    = op_from_funct(instr.r.funct3,
                                               instr.r.funct7 == rv_isa_pkg::F7_ALT);
                ctrl.reg_write = 1'b1;
            end
            rv_isa_pkg::OPC_OP_IMM:
            begin
                // Only SRAI takes the alternate form
                ctrl.alu_op    = op_from_funct(instr.i.funct3,
                                               instr.i.funct3 == rv_isa_pkg::F3_SR &&
                                               instr.i.imm[11:5] == rv_isa_pkg::F7_ALT);
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.imm       = {{(core_pkg::XLEN-12){instr.i.imm[11]}}, instr.i.imm};
            end
            rv_isa_pkg::OPC_LOAD:
            begin
                if (MEM_CAPABLE != 0 && instr.i.funct3 == rv_isa_pkg::F3_WORD)
                begin
                    ctrl.use_imm   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    ctrl.imm       = {{(core_pkg::XLEN-12){instr.i.imm[11]}}, instr.i.imm};
                end
            end
            rv_isa_pkg::OPC_STORE:
            begin
                if (MEM_CAPABLE != 0 && instr.s.funct3 == rv_isa_pkg::F3_WORD)
                begin
                    ctrl.use_imm   = 1'b1;
                    ctrl.mem_write = 1'b1;
                    ctrl.imm       = {{(core_pkg::XLEN-12){instr.s.imm_hi[6]}},
                                      instr.s.imm_hi, instr.s.imm_lo};
                end
            end
            default:
            begin
                // Unsupported opcodes leave every enable clear
            end
        endcase

        // x0 writes are dropped here
        if (!valid || ctrl.rd == '0)
        begin
            ctrl.reg_write = 1'b0;
        end
        if (!valid)
        begin
            ctrl.mem_read  = 1'b0;
            ctrl.mem_write = 1'b0;
        end
    end

endmodule

// ==== verilog/register_file.sv ====
module register_file (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [core_pkg::REG_IDX_W-1:0] rs_idx  [2*core_pkg::LANES],
    input  core_pkg::retire_t              wr      [core_pkg::LANES],
    output logic [core_pkg::XLEN-1:0]      rs_data [2*core_pkg::LANES]
);

    // x0 has no storage
    logic [core_pkg::XLEN-1:0] regs [1:2**core_pkg::REG_IDX_W-1];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int r = 1; r < 2**core_pkg::REG_IDX_W; r++)
            begin
                regs[r] <= '0;
            end
        end
        else
        begin
            // Higher lane written last, so it wins a clash
            for (int w = 0; w < core_pkg::LANES; w++)
            begin
                if (wr[w].valid && wr[w].rd != '0)
                begin
                    regs[wr[w].rd] <= wr[w].data;
                end
            end
        end
    end

    always_comb
    begin
        for (int p = 0; p < 2*core_pkg::LANES; p++)
        begin
            rs_data[p] = (rs_idx[p] == '0) ? '0 : regs[rs_idx[p]];
        end
    end

    // Decoder must have filtered x0 destinations
    for (genvar w = 0; w < core_pkg::LANES; w++)
    begin : g_wr_check
        a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
            wr[w].valid |-> wr[w].rd != '0);
    end

endmodule

// ==== verilog/alu.sv ====
module alu (
    input  logic [core_pkg::XLEN-1:0] op_a,
    input  logic [core_pkg::XLEN-1:0] op_b,
    input  logic [core_pkg::XLEN-1:0] imm,
    input  logic                      use_imm,
    input  core_pkg::alu_op_e         op,
    output logic [core_pkg::XLEN-1:0] result
);

    logic [core_pkg::XLEN-1:0] src_b;
    logic [4:0]                shamt;

    assign src_b = use_imm ? imm : op_b;
    assign shamt = src_b[4:0];

    always_comb
    begin
        case (op)
            core_pkg::ADD:  result = op_a + src_b;
            core_pkg::SUB:  result = op_a - src_b;
            core_pkg::SLL:  result = op_a << shamt;
            core_pkg::SLT:
            begin
                result = {{(core_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(src_b)};
            end
            core_pkg::SLTU:
            begin
                result = {{(core_pkg::XLEN-1){1'b0}}, op_a < src_b};
            end
            core_pkg::XOR:  result = op_a ^ src_b;
            core_pkg::SRL:  result = op_a >> shamt;
            core_pkg::SRA:  result = $unsigned($signed(op_a) >>> shamt);
            core_pkg::OR:   result = op_a | src_b;
            core_pkg::AND:  result = op_a & src_b;
            default:        result = '0;
        endcase
    end

endmodule

// ==== verilog/data_memory.sv ====
module data_memory (
    input  logic                            clk,
    input  logic [core_pkg::DMEM_IDX_W-1:0] addr,
    input  logic                            write_en,
    input  logic [core_pkg::XLEN-1:0]       write_data,
    output logic [core_pkg::XLEN-1:0]       read_data
);

    logic [core_pkg::XLEN-1:0] mem [core_pkg::DMEM_WORDS];

    always_ff @(posedge clk)
    begin
        if (write_en)
        begin
            mem[addr] <= write_data;
        end
    end

    // Asynchronous read
    assign read_data = mem[addr];

endmodule

// ==== verilog/dual_issue_core.sv ====
module dual_issue_core (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  pair_strobe,
    input  rv_isa_pkg::rv_instr_u instr_pair [core_pkg::LANES],
    output core_pkg::retire_t     retire     [core_pkg::LANES]
);

    rv_isa_pkg::rv_instr_u          decode_q     [core_pkg::LANES];
    logic [core_pkg::LANES-1:0]     decode_vld_q;
    core_pkg::ctrl_t                dec_ctrl     [core_pkg::LANES];
    logic [core_pkg::REG_IDX_W-1:0] rs_idx       [2*core_pkg::LANES];
    logic [core_pkg::XLEN-1:0]      rs_data      [2*core_pkg::LANES];
    core_pkg::issue_t               issue_q      [core_pkg::LANES];
    logic [core_pkg::LANES-1:0]     issue_vld_q;
    logic [core_pkg::XLEN-1:0]      alu_result   [core_pkg::LANES];
    core_pkg::exec_t                exec_q       [core_pkg::LANES];
    logic [core_pkg::LANES-1:0]     exec_vld_q;
    logic                           dmem_write;
    logic [core_pkg::XLEN-1:0]      load_data;
    core_pkg::retire_t              retire_d     [core_pkg::LANES];

    ////////////////////////////////////////
    // Valid chain and writeback register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            decode_vld_q <= '0;
            issue_vld_q  <= '0;
            exec_vld_q   <= '0;
            for (int l = 0; l < core_pkg::LANES; l++)
            begin
                retire[l] <= '0;
            end
        end
        else
        begin
            decode_vld_q <= {core_pkg::LANES{pair_strobe}};
            issue_vld_q  <= decode_vld_q;
            exec_vld_q   <= issue_vld_q;
            retire       <= retire_d;
        end
    end

    // Stage payloads
    always_ff @(posedge clk)
    begin
        for (int l = 0; l < core_pkg::LANES; l++)
        begin
            if (pair_strobe)
            begin
                decode_q[l] <= instr_pair[l];
            end
            issue_q[l].ctrl      <= dec_ctrl[l];
            issue_q[l].op_a      <= rs_data[2*l];
            issue_q[l].op_b      <= rs_data[2*l+1];
            exec_q[l].ctrl       <= issue_q[l].ctrl;
            exec_q[l].result     <= alu_result[l];
            exec_q[l].store_data <= issue_q[l].op_b;
        end
    end

    ////////////////////////////////////////
    // Decode and execute per lane
    ////////////////////////////////////////

    for (genvar l = 0; l < core_pkg::LANES; l++)
    begin : g_lane
        instr_decoder #(
            .MEM_CAPABLE(l == core_pkg::MEM_LANE)
        ) i_instr_decoder (
            .instr (decode_q[l]),
            .valid (decode_vld_q[l]),
            .ctrl  (dec_ctrl[l]),
            .rs1   (rs_idx[2*l]),
            .rs2   (rs_idx[2*l+1])
        );

        alu i_alu (
            .op_a    (issue_q[l].op_a),
            .op_b    (issue_q[l].op_b),
            .imm     (issue_q[l].ctrl.imm),
            .use_imm (issue_q[l].ctrl.use_imm),
            .op      (issue_q[l].ctrl.alu_op),
            .result  (alu_result[l])
        );
    end

    register_file i_register_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_idx  (rs_idx),
        .wr      (retire),
        .rs_data (rs_data)
    );

    ////////////////////////////////////////
    // Memory stage
    ////////////////////////////////////////

    assign dmem_write = exec_vld_q[core_pkg::MEM_LANE] &&
                        exec_q[core_pkg::MEM_LANE].ctrl.mem_write;

    // Word index from the effective address
    data_memory i_data_memory (
        .clk        (clk),
        .addr       (exec_q[core_pkg::MEM_LANE].result[core_pkg::DMEM_IDX_W+1:2]),
        .write_en   (dmem_write),
        .write_data (exec_q[core_pkg::MEM_LANE].store_data),
        .read_data  (load_data)
    );

    always_comb
    begin
        for (int l = 0; l < core_pkg::LANES; l++)
        begin
            retire_d[l].valid = exec_vld_q[l] && exec_q[l].ctrl.reg_write;
            retire_d[l].rd    = exec_q[l].ctrl.rd;
            retire_d[l].data  = exec_q[l].result;
        end
        if (exec_q[core_pkg::MEM_LANE].ctrl.mem_read)
        begin
            retire_d[core_pkg::MEM_LANE].data = load_data;
        end
    end

    // Lane 0 decoder is built without memory support
    a_lane0_no_mem: assert property (@(posedge clk) disable iff (!arst_n)
        exec_vld_q[0] |-> !(exec_q[0].ctrl.mem_read || exec_q[0].ctrl.mem_write));

endmodule

// ==== tests/core_tb.sv ====
module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PAIRS = 400;
    // Expected entries are held one stage per cycle from strobe to retire
    localparam int DEPTH = 5;
    localparam int TIMEOUT_CYCLES = (NUM_PAIRS * 3 + 20) * 2;

    logic                  clk;
    logic                  arst_n;
    logic                  pair_strobe;
    rv_isa_pkg::rv_instr_u instr_pair [core_pkg::LANES];
    core_pkg::retire_t     retire     [core_pkg::LANES];

    // Architectural model
    logic [31:0]       model_regs  [32];
    logic [31:0]       model_mem   [core_pkg::DMEM_WORDS];
    logic              mem_written [core_pkg::DMEM_WORDS];
    int                stored_idx  [$];
    logic [4:0]        recent_rd   [3][2];
    core_pkg::retire_t exp_pipe    [DEPTH][2];
    string             name_pipe   [DEPTH][2];

    dual_issue_core i_dual_issue_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .pair_strobe (pair_strobe),
        .instr_pair  (instr_pair),
        .retire      (retire)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            rv_isa_pkg::F3_ADD:  return alt ? a - b : a + b;
            rv_isa_pkg::F3_SLL:  return a << b[4:0];
            rv_isa_pkg::F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
            rv_isa_pkg::F3_SLTU: return {31'b0, a < b};
            rv_isa_pkg::F3_XOR:  return a ^ b;
            rv_isa_pkg::F3_SR:   return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            rv_isa_pkg::F3_OR:   return a | b;
            default:             return a & b;
        endcase
    endfunction

    // Sources avoid anything still in flight
    function automatic logic [4:0] pick_src();
        logic [4:0] r;
        logic       busy;
        do
        begin
            r    = 5'($urandom);
            busy = 1'b0;
            for (int i = 0; i < 3; i++)
            begin
                for (int j = 0; j < 2; j++)
                begin
                    if (r != 5'd0 && recent_rd[i][j] == r)
                    begin
                        busy = 1'b1;
                    end
                end
            end
        end
        while (busy);
        return r;
    endfunction

    task automatic make_lane(input int lane, input logic [4:0] force_rd, input logic use_force,
                             output rv_isa_pkg::rv_instr_u ins,
                             output core_pkg::retire_t exp, output string name);
        int          kind;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [7:0]  idx;
        logic [9:0]  off;
        ins  = '0;
        exp  = '0;
        rd   = use_force ? force_rd : 5'($urandom);
        rs1  = pick_src();
        rs2  = pick_src();
        f3   = 3'($urandom);
        alt  = 1'($urandom);
        kind = int'($urandom % 10);
        a    = model_regs[rs1];
        b    = model_regs[rs2];
        if (f3 != rv_isa_pkg::F3_ADD && f3 != rv_isa_pkg::F3_SR)
        begin
            alt = 1'b0;
        end
        if (kind <= 3)
        begin
            ins.r.opcode = rv_isa_pkg::OPC_OP;
            ins.r.funct7 = alt ? rv_isa_pkg::F7_ALT : 7'd0;
            ins.r.rs2    = rs2;
            ins.r.rs1    = rs1;
            ins.r.funct3 = f3;
            ins.r.rd     = rd;
            exp.valid    = (rd != 5'd0);
            exp.rd       = rd;
            exp.data     = alu_model(f3, alt, a, b);
            name         = "r_type";
        end
        else if (kind <= 6)
        begin
            // No SUBI, and shifts keep the upper immediate bits canonical
            alt = alt && (f3 == rv_isa_pkg::F3_SR);
            imm = 12'($urandom);
            if (f3 == rv_isa_pkg::F3_SLL || f3 == rv_isa_pkg::F3_SR)
            begin
                imm[11:5] = alt ? rv_isa_pkg::F7_ALT : 7'd0;
            end
            ins.i.opcode = rv_isa_pkg::OPC_OP_IMM;
            ins.i.imm    = imm;
            ins.i.rs1    = rs1;
            ins.i.funct3 = f3;
            ins.i.rd     = rd;
            exp.valid    = (rd != 5'd0);
            exp.rd       = rd;
            exp.data     = alu_model(f3, alt, a, {{20{imm[11]}}, imm});
            name         = "i_type";
        end
        else if (kind == 7)
        begin
            if (stored_idx.size() > 0)
            begin
                idx = 8'(stored_idx[$urandom % stored_idx.size()]);
            end
            else
            begin
                idx = 8'($urandom);
                rd  = 5'd0;
            end
            off          = {idx, 2'b00} - a[9:0];
            imm          = {2'b00, off};
            ins.i.opcode = rv_isa_pkg::OPC_LOAD;
            ins.i.imm    = imm;
            ins.i.rs1    = rs1;
            ins.i.funct3 = rv_isa_pkg::F3_WORD;
            ins.i.rd     = rd;
            exp.valid    = (lane == 1) && (rd != 5'd0);
            exp.rd       = rd;
            exp.data     = model_mem[idx];
            name         = "load";
        end
        else if (kind == 8)
        begin
            idx            = 8'($urandom);
            off            = {idx, 2'b00} - a[9:0];
            imm            = {2'b00, off};
            ins.s.opcode   = rv_isa_pkg::OPC_STORE;
            ins.s.imm_hi   = imm[11:5];
            ins.s.imm_lo   = imm[4:0];
            ins.s.rs2      = rs2;
            ins.s.rs1      = rs1;
            ins.s.funct3   = rv_isa_pkg::F3_WORD;
            name           = "store";
            if (lane == 1)
            begin
                model_mem[idx] = b;
                if (!mem_written[idx])
                begin
                    mem_written[idx] = 1'b1;
                    stored_idx.push_back(int'(idx));
                end
            end
        end
        else
        begin
            // LUI is outside the subset
            ins.r        = $urandom;
            ins.r.opcode = 7'b0110111;
            name         = "unsupported";
        end
        if (lane == 0 && (kind == 7 || kind == 8))
        begin
            exp  = '0;
            name = "lane0_mem";
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic advance(input logic strobe);
        rv_isa_pkg::rv_instr_u ins0;
        rv_isa_pkg::rv_instr_u ins1;
        core_pkg::retire_t     e0;
        core_pkg::retire_t     e1;
        string                 n0;
        string                 n1;
        logic                  same;
        @(posedge clk);
        for (int d = DEPTH - 1; d > 0; d--)
        begin
            exp_pipe[d]  = exp_pipe[d-1];
            name_pipe[d] = name_pipe[d-1];
        end
        exp_pipe[0][0]  = '0;
        exp_pipe[0][1]  = '0;
        name_pipe[0][0] = "idle";
        name_pipe[0][1] = "idle";
        if (strobe)
        begin
            make_lane(0, 5'd0, 1'b0, ins0, e0, n0);
            same = (($urandom % 6) == 0);
            make_lane(1, ins0.r.rd, same, ins1, e1, n1);
            // Lane 1 lands last on a shared rd
            if (e0.valid)
            begin
                model_regs[e0.rd] = e0.data;
            end
            if (e1.valid)
            begin
                model_regs[e1.rd] = e1.data;
            end
            recent_rd[2]    = recent_rd[1];
            recent_rd[1]    = recent_rd[0];
            recent_rd[0][0] = ins0.r.rd;
            recent_rd[0][1] = ins1.r.rd;
            exp_pipe[0][0]  = e0;
            exp_pipe[0][1]  = e1;
            name_pipe[0][0] = n0;
            name_pipe[0][1] = n1;
            pair_strobe    <= 1'b1;
            instr_pair[0]  <= ins0;
            instr_pair[1]  <= ins1;
        end
        else
        begin
            pair_strobe <= 1'b0;
        end
    endtask

    initial
    begin
        int idle;
        void'($urandom(32'h32bf));
        arst_n        = 1'b0;
        pair_strobe   = 1'b0;
        instr_pair[0] = '0;
        instr_pair[1] = '0;
        for (int r = 0; r < 32; r++)
        begin
            model_regs[r] = '0;
        end
        for (int m = 0; m < core_pkg::DMEM_WORDS; m++)
        begin
            model_mem[m]   = '0;
            mem_written[m] = 1'b0;
        end
        for (int d = 0; d < DEPTH; d++)
        begin
            for (int l = 0; l < 2; l++)
            begin
                exp_pipe[d][l]  = '0;
                name_pipe[d][l] = "idle";
            end
        end
        for (int i = 0; i < 3; i++)
        begin
            recent_rd[i][0] = 5'd0;
            recent_rd[i][1] = 5'd0;
        end
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        for (int n = 0; n < NUM_PAIRS; n++)
        begin
            idle = int'($urandom % 3);
            repeat (idle) advance(1'b0);
            advance(1'b1);
        end
        repeat (DEPTH + 2) advance(1'b0);
        $display("TESTBENCH PASSED");
        $finish;
    end

    ////////////////////////////////////////
    // Checks and watchdog
    ////////////////////////////////////////

    always @(negedge clk)
    begin
        if (arst_n)
        begin
            for (int l = 0; l < 2; l++)
            begin
                assert (exp_pipe[DEPTH-1][l].valid ? retire[l] == exp_pipe[DEPTH-1][l]
                                                   : !retire[l].valid)
                else
                begin
                    $write("FAILED %s lane %0d: expected valid=%0b rd=%0d data=%08h",
                           name_pipe[DEPTH-1][l], l, exp_pipe[DEPTH-1][l].valid,
                           exp_pipe[DEPTH-1][l].rd, exp_pipe[DEPTH-1][l].data);
                    $display(", actual valid=%0b rd=%0d data=%08h",
                             retire[l].valid, retire[l].rd, retire[l].data);
                    $display("TESTBENCH FAILED");
                    $fatal(1, "retire mismatch");
                end
            end
        end
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== compile.f ====
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/alu.sv
verilog/data_memory.sv
verilog/dual_issue_core.sv
tests/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module core_tb -o core_tb_sim || exit 1
out=$(./obj_dir/core_tb_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TESTBENCH PASSED" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
